// ==== compile.f ====
+incdir+verilog
verilog/apb_event_pkg.sv
verilog/event_capture.sv
verilog/event_fifo.sv
verilog/apb_write_master.sv
verilog/apb_event_bridge.sv
bench/apb_event_bridge_tb.sv

// ==== bench/apb_event_bridge_tb.sv ====
`timescale 1ns/1ps

`include "apb_event_settings.svh"

module apb_event_bridge_tb;

  import apb_event_pkg::*;

  localparam int          RESET_CYCLES     = 8;
  localparam int          ISOLATED_EVENTS  = 20;
  localparam int          TOTAL_EVENTS     = 100;
  // Worst case per event, including wait states and gaps
  localparam int          CYCLES_PER_EVENT = 40;
  localparam int          TIMEOUT_CYCLES   = TOTAL_EVENTS * CYCLES_PER_EVENT;
  // Master, full FIFO and one held pending bit, so no event merges
  localparam int          MAX_OUTSTANDING  = `APB_EVENT_FIFO_DEPTH + 2;
  // Same event again only after its pending bit has surely cleared
  localparam int          REISSUE_GAP      = 6;
  // Quiet bus well past the four cycle path from pulse to psel
  localparam int          IDLE_WINDOW      = 8;
  localparam logic [31:0] SEED             = 32'd26;

  logic        clk;
  logic        rst;
  logic        event_a_i;
  logic        event_b_i;
  logic        event_c_i;
  logic        pready_i;
  apb_req_t    apb_o;

  // Reference model state
  event_id_e   exp_q[$];
  logic [31:0] exp_data;
  int          issued;
  int          xfer_count;
  int          last_issue[3];
  bit          strict_order;
  apb_req_t    held_req;

  // Separate random streams for events and wait states
  logic [31:0] ev_state;
  logic [31:0] rdy_state;
  int          cycle_cnt;

  apb_event_bridge i_apb_event_bridge (
    .clk       (clk),
    .rst       (rst),
    .event_a_i (event_a_i),
    .event_b_i (event_b_i),
    .event_c_i (event_c_i),
    .pready_i  (pready_i),
    .apb_o     (apb_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_event_rand();
    ev_state = xorshift32(ev_state);
    return ev_state;
  endfunction

  function automatic logic [31:0] event_addr(input event_id_e id);
    case (id)
      EV_A:    return `APB_EVENT_ADDR_A;
      EV_B:    return `APB_EVENT_ADDR_B;
      default: return `APB_EVENT_ADDR_C;
    endcase
  endfunction

  function automatic string req_text(input apb_req_t r);
    return $sformatf("sel=%b en=%b wr=%b addr=%h data=%h",
                     r.psel, r.penable, r.pwrite, r.paddr, r.pwdata);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_apb(input string name, input apb_req_t exp, input apb_req_t act);
    if (act !== exp) begin
      abort_run($sformatf("error %s expected %s actual %s",
                          name, req_text(exp), req_text(act)));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("error %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  // Events of one cycle enter the model in priority order a, b, c
  task automatic queue_events(input logic [2:0] mask);
    for (int i = 0; i < 3; i++) begin
      if (mask[i]) begin
        exp_q.push_back(event_id_e'(i));
        last_issue[i] = cycle_cnt;
        issued++;
      end
    end
  endtask

  task automatic drive_events(input logic [2:0] mask);
    @(posedge clk);
    event_a_i <= mask[0];
    event_b_i <= mask[1];
    event_c_i <= mask[2];
  endtask

  // Bus quiet for a whole window, so no event is still on its way
  task automatic wait_bus_idle();
    int quiet;
    quiet = 0;
    while (quiet < IDLE_WINDOW) begin
      @(negedge clk);
      if (apb_o.psel) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  task automatic issue_burst_cycle();
    logic [31:0] r;
    logic [2:0]  mask;
    @(negedge clk);
    r    = next_event_rand();
    mask = r[2:0];
    for (int i = 0; i < 3; i++) begin
      if (cycle_cnt - last_issue[i] < REISSUE_GAP) begin
        mask[i] = 1'b0;
      end
    end
    if (issued - xfer_count + $countones(mask) > MAX_OUTSTANDING) begin
      mask = 3'b000;
    end
    queue_events(mask);
    drive_events(mask);
  endtask

  // Slave side of a completed write
  task automatic record_transfer();
    apb_req_t exp;
    int       idx;
    idx = 0;
    if (exp_q.size() == 0) begin
      abort_run("APB write completed with no event outstanding");
    end
    // Under back-pressure the order between cycles may shift
    if (!strict_order) begin
      for (int i = exp_q.size() - 1; i >= 0; i--) begin
        if (event_addr(exp_q[i]) == apb_o.paddr) begin
          idx = i;
        end
      end
    end
    exp.psel    = 1'b1;
    exp.penable = 1'b1;
    exp.pwrite  = 1'b1;
    exp.paddr   = event_addr(exp_q[idx]);
    exp.pwdata  = exp_data;
    check_apb("completed write", exp, apb_o);
    exp_q.delete(idx);
    exp_data = exp_data + `APB_EVENT_DATA_STEP;
    xfer_count++;
  endtask

  // Ready high five cycles in eight
  always @(posedge clk) begin
    rdy_state <= xorshift32(rdy_state);
    pready_i  <= (rdy_state[2:0] > 3'd2);
  end

  always @(posedge clk) begin : bus_monitor
    apb_req_t exp;
    if (rst && apb_o.psel) begin
      if (!apb_o.penable) begin
        held_req = apb_o;
      end else begin
        // ACCESS repeats the SETUP payload
        exp         = held_req;
        exp.penable = 1'b1;
        check_apb("payload held in ACCESS", exp, apb_o);
        if (pready_i) begin
          record_transfer();
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout, the bus did not finish the issued events in time");
    end
  end

  initial begin
    rst          = 1'b0;
    event_a_i    = 1'b0;
    event_b_i    = 1'b0;
    event_c_i    = 1'b0;
    pready_i     = 1'b0;
    ev_state     = SEED;
    rdy_state    = SEED ^ 32'h9E37_79B9;
    exp_data     = '0;
    issued       = 0;
    xfer_count   = 0;
    cycle_cnt    = 0;
    strict_order = 1'b1;
    held_req     = '0;
    last_issue   = '{-100, -100, -100};

    // Reset state
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_apb("reset", '0, apb_o);
    end
    @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_apb("first cycle after reset", '0, apb_o);

    // Isolated events
    for (int n = 0; n < ISOLATED_EVENTS; n++) begin
      wait_bus_idle();
      queue_events(3'b001 << (next_event_rand() % 3));
      drive_events(3'b001 << exp_q[exp_q.size() - 1]);
      drive_events(3'b000);
      wait_bus_idle();
      check_count("isolated event", issued, xfer_count);
    end

    // All three events in one cycle
    queue_events(3'b111);
    drive_events(3'b111);
    drive_events(3'b000);
    wait_bus_idle();
    check_count("priority burst", issued, xfer_count);

    // Random bursts against random wait states
    strict_order = 1'b0;
    while (issued < TOTAL_EVENTS) begin
      issue_burst_cycle();
    end
    drive_events(3'b000);
    wait_bus_idle();
    check_count("final transfer count", issued, xfer_count);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== verilog/apb_event_bridge.sv ====
`timescale 1ns/1ps

`include "apb_event_settings.svh"

module apb_event_bridge (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    event_a_i,
  input  logic                    event_b_i,
  input  logic                    event_c_i,
  input  logic                    pready_i,
  output apb_event_pkg::apb_req_t apb_o
);

  import apb_event_pkg::*;

  // Capture to FIFO
  logic       push;
  event_rec_t push_rec;
  logic       full;

  // FIFO to bus master
  logic       pop;
  event_rec_t pop_rec;
  logic       empty;

  event_capture i_event_capture (
    .clk        (clk),
    .rst        (rst),
    .event_a_i  (event_a_i),
    .event_b_i  (event_b_i),
    .event_c_i  (event_c_i),
    .full_i     (full),
    .push_o     (push),
    .push_rec_o (push_rec)
  );

  event_fifo #(
    .DEPTH (`APB_EVENT_FIFO_DEPTH)
  ) i_event_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_i     (push),
    .push_rec_i (push_rec),
    .pop_i      (pop),
    .full_o     (full),
    .empty_o    (empty),
    .pop_rec_o  (pop_rec)
  );

  apb_write_master i_apb_write_master (
    .clk       (clk),
    .rst       (rst),
    .empty_i   (empty),
    .pop_rec_i (pop_rec),
    .pop_o     (pop),
    .pready_i  (pready_i),
    .apb_o     (apb_o)
  );

endmodule

// ==== verilog/apb_write_master.sv ====
`timescale 1ns/1ps

`include "apb_event_settings.svh"

module apb_write_master (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      empty_i,
  input  apb_event_pkg::event_rec_t pop_rec_i,
  output logic                      pop_o,
  input  logic                      pready_i,
  output apb_event_pkg::apb_req_t   apb_o
);

  import apb_event_pkg::*;

  apb_state_e  state_q;
  apb_state_e  state_nxt;

  // Running write data bumped once per finished transfer
  logic [31:0] data_q;
  logic [31:0] data_nxt;

  // Address and data held for the whole transfer
  logic [31:0] paddr_q;
  logic [31:0] pwdata_q;

  logic [31:0] rec_addr;
  logic        done;

  // Event ID to slave address
  always_comb begin
    case (pop_rec_i.id)
      EV_A:    rec_addr = `APB_EVENT_ADDR_A;
      EV_B:    rec_addr = `APB_EVENT_ADDR_B;
      default: rec_addr = `APB_EVENT_ADDR_C;
    endcase
  end

  // Transfer ends on the first ready edge in ACCESS
  assign done     = (state_q == ST_ACCESS) && pready_i;
  assign data_nxt = done ? data_q + `APB_EVENT_DATA_STEP : data_q;

  always_comb begin
    state_nxt = state_q;
    pop_o     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (!empty_i) begin
          pop_o     = 1'b1;
          state_nxt = ST_SETUP;
        end
      end
      // Exactly one cycle
      ST_SETUP: begin
        state_nxt = ST_ACCESS;
      end
      ST_ACCESS: begin
        if (pready_i) begin
          // Back to back when more records wait
          if (!empty_i) begin
            pop_o     = 1'b1;
            state_nxt = ST_SETUP;
          end else begin
            state_nxt = ST_IDLE;
          end
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q  <= ST_IDLE;
      data_q   <= '0;
      paddr_q  <= '0;
      pwdata_q <= '0;
    end else begin
      state_q <= state_nxt;
      data_q  <= data_nxt;
      // Load on the pop edge, so SETUP already shows the new values
      // data_nxt covers the back to back case where data_q moves too
      if (pop_o) begin
        paddr_q  <= rec_addr;
        pwdata_q <= data_nxt;
      end
    end
  end

  // Bus strobes decoded from the state register
  always_comb begin
    apb_o.psel    = (state_q != ST_IDLE);
    apb_o.penable = (state_q == ST_ACCESS);
    apb_o.pwrite  = (state_q != ST_IDLE);
    apb_o.paddr   = paddr_q;
    apb_o.pwdata  = pwdata_q;
  end

  // Address and data frozen until the transfer completes
  a_stable_payload: assert property (
    @(posedge clk) disable iff (!rst)
    (apb_o.psel && !(apb_o.penable && pready_i))
      |=> $stable(apb_o.paddr) && $stable(apb_o.pwdata)
  ) else $error("APB address or data changed mid transfer");

endmodule

// ==== verilog/event_fifo.sv ====
`timescale 1ns/1ps

`include "apb_event_settings.svh"

module event_fifo #(
  parameter int DEPTH = `APB_EVENT_FIFO_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push_i,
  input  apb_event_pkg::event_rec_t push_rec_i,
  input  logic                      pop_i,
  output logic                      full_o,
  output logic                      empty_o,
  output apb_event_pkg::event_rec_t pop_rec_o
);

  import apb_event_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Record storage
  event_rec_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Levels straight from the occupancy count
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // Head word is valid while not empty
  assign pop_rec_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_rec_i;
    end
  end

  // Pointers wrap at DEPTH, so depth need not be a power of two
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Upstream must respect the full level
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst)
    push_i |-> !full_o
  ) else $error("event_fifo push while full");

  // Downstream must respect the empty level
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst)
    pop_i |-> !empty_o
  ) else $error("event_fifo pop while empty");

endmodule

// ==== verilog/event_capture.sv ====
`timescale 1ns/1ps

module event_capture (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     event_a_i,
  input  logic                     event_b_i,
  input  logic                     event_c_i,
  input  logic                     full_i,
  output logic                     push_o,
  output apb_event_pkg::event_rec_t push_rec_o
);

  import apb_event_pkg::*;

  // Bit 0 is event a, bit 2 is event c
  logic [2:0] pending_q;
  logic [2:0] pending_nxt;
  logic [2:0] grant;
  logic [2:0] clear;

  // Pick the highest-priority pending event
  always_comb begin
    grant         = 3'b000;
    push_rec_o.id = EV_C;
    if (pending_q[0]) begin
      grant         = 3'b001;
      push_rec_o.id = EV_A;
    end else if (pending_q[1]) begin
      grant         = 3'b010;
      push_rec_o.id = EV_B;
    end else if (pending_q[2]) begin
      grant         = 3'b100;
      push_rec_o.id = EV_C;
    end
  end

  // Forward only while the queue has room
  assign push_o = (|pending_q) && !full_i;

  // Pushed bit drops on the write edge
  assign clear = push_o ? grant : 3'b000;

  // A new pulse wins over the clear, so nothing is lost on that edge
  // Repeats of a bit still pending simply merge
  assign pending_nxt = (pending_q & ~clear) | {event_c_i, event_b_i, event_a_i};

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pending_q <= 3'b000;
    end else begin
      pending_q <= pending_nxt;
    end
  end

endmodule

// ==== verilog/apb_event_pkg.sv ====
package apb_event_pkg;

  // Source event with a at the highest priority
  typedef enum logic [1:0] {
    EV_A = 2'd0,
    EV_B = 2'd1,
    EV_C = 2'd2
  } event_id_e;

  // Bus master sequence
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SETUP  = 2'd1,
    ST_ACCESS = 2'd2
  } apb_state_e;

  // One queued event as held in the FIFO
  typedef struct packed {
    event_id_e id;
  } event_rec_t;

  // 67-bit APB request side toward the slave
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

endpackage

// ==== verilog/apb_event_settings.svh ====
`ifndef APB_EVENT_SETTINGS_SVH
`define APB_EVENT_SETTINGS_SVH

// Target address of each event source
`define APB_EVENT_ADDR_A 32'h1000_1000
`define APB_EVENT_ADDR_B 32'h2000_2000
`define APB_EVENT_ADDR_C 32'h3000_3000

// Added to the write data once per completed transfer
`define APB_EVENT_DATA_STEP 32'hDEAD_CAFE

// Event records held between capture and the bus master
// Any depth of two or more works
`define APB_EVENT_FIFO_DEPTH 4

`endif
